/* Makefile */
TOP := cache_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module $(TOP) -f cache.f

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -qx "TEST PASS" sim.log

lint:
	verilator --lint-only --timing --assert -Wall --timescale 1ns/1ps --top-module $(TOP) -f cache.f

clean:
	rm -rf obj_dir sim.log

/* cache.f */
cache_pkg.sv
cache_tag_array.sv
cache_data_array.sv
cache_ctrl.sv
main_memory.sv
cache_top.sv
cache_properties.sv
cache_tb.sv

/* cache_ctrl.sv */
module cache_ctrl
    import cache_pkg::*;
(
    input  logic              clk,
    input  logic              reset_n,
    input  logic              i_rd,
    input  logic              i_wr,
    input  logic [WORD_W-1:0] i_addr,
    input  logic [WORD_W-1:0] i_wdata,
    input  logic              i_hit,
    input  logic              i_hit_way,
    input  logic              i_victim_way,
    input  logic [WORD_W-1:0] i_rword,
    input  logic              i_mem_ack,
    input  logic [LINE_W-1:0] i_mem_rline,
    output logic              o_ready,
    output logic              o_done,
    output logic [WORD_W-1:0] o_rdata,
    output logic              o_hit,
    output logic [WORD_W-1:0] o_arr_addr,
    output logic              o_arr_way,
    output logic              o_touch,
    output logic              o_tag_fill,
    output logic              o_data_wr,
    output logic              o_data_fill,
    output logic [LINE_W-1:0] o_fill_line,
    output logic [WORD_W-1:0] o_wdata,
    output logic              o_mem_rd,
    output logic              o_mem_wr,
    output logic [WORD_W-1:0] o_mem_addr,
    output logic [WORD_W-1:0] o_mem_wdata
);

    ctrl_state_t       state;
    logic [WORD_W-1:0] req_addr;
    logic [WORD_W-1:0] req_wdata;
    logic              req_wr;
    logic [LINE_W-1:0] line_q;
    logic              accept;

    // Ready again in the fill cycle, which also carries o_done
    assign o_ready = (state == ST_IDLE) || (state == ST_FILL);
    assign accept  = o_ready && (i_rd || i_wr);

    // Array side
    assign o_arr_addr  = req_addr;
    assign o_arr_way   = (state == ST_FILL) ? i_victim_way : i_hit_way;
    assign o_touch     = (state == ST_LOOKUP) && i_hit;
    assign o_data_wr   = o_touch && req_wr;
    assign o_tag_fill  = (state == ST_FILL);
    assign o_data_fill = (state == ST_FILL);
    assign o_fill_line = line_q;
    assign o_wdata     = req_wdata;

    // Write-through leaves in the lookup cycle, hit or miss
    assign o_mem_wr    = (state == ST_LOOKUP) && req_wr;
    assign o_mem_addr  = req_wr ? req_addr : {req_addr[WORD_W-1:OFF_W], {OFF_W{1'b0}}};
    assign o_mem_wdata = req_wdata;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state    <= ST_IDLE;
            o_done   <= 1'b0;
            o_hit    <= 1'b0;
            o_mem_rd <= 1'b0;
        end else begin
            o_done   <= 1'b0;
            o_mem_rd <= 1'b0;
            case (state)
                ST_IDLE, ST_FILL: begin
                    state <= accept ? ST_LOOKUP : ST_IDLE;
                end
                ST_LOOKUP: begin
                    o_hit <= i_hit;
                    if (req_wr) begin
                        state <= ST_MEM_WR;
                    end else if (i_hit) begin
                        state  <= ST_IDLE;
                        o_done <= 1'b1;
                    end else begin
                        // Line read goes out next cycle
                        state    <= ST_MEM_RD;
                        o_mem_rd <= 1'b1;
                    end
                end
                ST_MEM_RD: begin
                    if (i_mem_ack) begin
                        state  <= ST_FILL;
                        o_done <= 1'b1;
                    end
                end
                ST_MEM_WR: begin
                    if (i_mem_ack) begin
                        state  <= ST_IDLE;
                        o_done <= 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_addr  <= i_addr;
            req_wdata <= i_wdata;
            req_wr    <= i_wr;
        end
        if ((state == ST_LOOKUP) && i_hit && !req_wr) begin
            o_rdata <= i_rword;
        end
        // Keep the line for the fill and pick out the requested word
        if ((state == ST_MEM_RD) && i_mem_ack) begin
            line_q  <= i_mem_rline;
            o_rdata <= i_mem_rline[req_addr[OFF_W-1:0]*WORD_W +: WORD_W];
        end
    end

endmodule

/* cache_data_array.sv */
module cache_data_array
    import cache_pkg::*;
(
    input  logic              clk,
    input  logic [OFF_W:0]    i_addr,
    input  logic              i_way,
    input  logic              i_wr,
    input  logic [OFF_W-1:0]  i_wr_off,
    input  logic [WORD_W-1:0] i_wdata,
    input  logic              i_fill,
    input  logic [LINE_W-1:0] i_fill_line,
    output logic [WORD_W-1:0] o_rword
);

    // One line per set and way
    logic [LINE_W-1:0] line_q [NUM_SETS*2];
    logic [1:0]        line_idx;
    logic [OFF_W-1:0]  rd_off;

    // Set bit above the way bit
    assign line_idx = {i_addr[OFF_W], i_way};
    assign rd_off   = i_addr[OFF_W-1:0];

    assign o_rword = line_q[line_idx][rd_off*WORD_W +: WORD_W];

    always_ff @(posedge clk) begin
        if (i_fill) begin
            line_q[line_idx] <= i_fill_line;
        end else if (i_wr) begin
            // Merge one word on a write hit
            line_q[line_idx][i_wr_off*WORD_W +: WORD_W] <= i_wdata;
        end
    end

endmodule

/* cache_pkg.sv */
package cache_pkg;

    // Processor word, also the width of a word address
    parameter int WORD_W = 16;

    // Line geometry
    parameter int LINE_WORDS = 4;
    parameter int LINE_W = WORD_W * LINE_WORDS;

    // Address split: tag in 15..3, set in bit 2, word offset in 1..0
    parameter int OFF_W = 2;
    parameter int TAG_W = 13;

    // Two sets, selected by the address bit just above the offset
    parameter int NUM_SETS = 2;

    // Controller states
    typedef enum logic [2:0] {
        // Waiting for a processor strobe
        ST_IDLE,
        // Tag compare against the latched address
        ST_LOOKUP,
        // Line read outstanding at main memory
        ST_MEM_RD,
        // Returned line written into the arrays
        ST_FILL,
        // Write-through outstanding at main memory
        ST_MEM_WR
    } ctrl_state_t;

endpackage

/* cache_properties.sv */
module cache_properties (
    input logic clk,
    input logic reset_n,
    input logic i_rd,
    input logic i_wr,
    input logic i_hit,
    input logic i_mem_ack,
    input logic o_ready,
    input logic o_done
);

    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;

    // Done is a single-cycle strobe
    done_one_cycle: assert property (@(posedge clk) disable iff (!reset_n)
        o_done |=> !o_done)
        else begin
            $error("o_done held for more than one cycle");
            fail_count++;
        end

    strobe_when_ready: assert property (@(posedge clk) disable iff (!reset_n)
        (i_rd || i_wr) |-> o_ready)
        else begin
            $error("request strobe while o_ready is low");
            fail_count++;
        end

    // Memory answers only a request of the access in progress
    mem_ack_when_busy: assert property (@(posedge clk) disable iff (!reset_n)
        i_mem_ack |-> !o_ready)
        else begin
            $error("memory acknowledge while no access was in progress");
            fail_count++;
        end

    // Read hit finishes two cycles after its strobe
    read_hit_latency: assert property (@(posedge clk) disable iff (!reset_n)
        ($past(o_ready && i_rd) && i_hit) |=> o_done)
        else begin
            $error("read hit did not finish two cycles after its strobe");
            fail_count++;
        end

endmodule

/* cache_tag_array.sv */
module cache_tag_array
    import cache_pkg::*;
(
    input  logic              clk,
    input  logic              reset_n,
    input  logic [WORD_W-1:0] i_lookup_addr,
    input  logic              i_touch,
    input  logic              i_touch_way,
    input  logic              i_fill,
    input  logic              i_fill_way,
    input  logic [WORD_W-1:0] i_fill_addr,
    output logic              o_hit,
    output logic              o_hit_way,
    output logic              o_victim_way
);

    logic [1:0]          valid_q [NUM_SETS];
    logic [TAG_W-1:0]    tag_q   [NUM_SETS][2];
    logic [NUM_SETS-1:0] lru_q;
    logic                set_sel;
    logic                fill_set;
    logic [TAG_W-1:0]    lookup_tag;
    logic [1:0]          match;

    assign set_sel    = i_lookup_addr[OFF_W];
    assign fill_set   = i_fill_addr[OFF_W];
    assign lookup_tag = i_lookup_addr[WORD_W-1 -: TAG_W];

    // Compare both ways of the indexed set
    assign match[0] = valid_q[set_sel][0] && (tag_q[set_sel][0] == lookup_tag);
    assign match[1] = valid_q[set_sel][1] && (tag_q[set_sel][1] == lookup_tag);
    assign o_hit     = |match;
    assign o_hit_way = match[1];

    // Empty way first, otherwise the one the LRU bit names
    always_comb begin
        if (!valid_q[set_sel][0]) begin
            o_victim_way = 1'b0;
        end else if (!valid_q[set_sel][1]) begin
            o_victim_way = 1'b1;
        end else begin
            o_victim_way = lru_q[set_sel];
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid_q[s] <= 2'b00;
            end
            lru_q <= '0;
        end else begin
            // LRU points away from the way just used
            if (i_touch) begin
                lru_q[set_sel] <= ~i_touch_way;
            end
            if (i_fill) begin
                valid_q[fill_set][i_fill_way] <= 1'b1;
                lru_q[fill_set]               <= ~i_fill_way;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_fill) begin
            tag_q[fill_set][i_fill_way] <= i_fill_addr[WORD_W-1 -: TAG_W];
        end
    end

endmodule

/* cache_tb.sv */
module cache_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int MEM_LATENCY  = 4;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_OPS      = 400;
    localparam int TIMEOUT      = 50;

    // Random addresses share this tag prefix, so only four tags compete per set
    localparam logic [10:0] TAG_BASE = 11'h2A7;

    logic        clk;
    logic        reset_n;
    logic        i_rd;
    logic        i_wr;
    logic [15:0] i_addr;
    logic [15:0] i_wdata;
    logic        o_ready;
    logic        o_done;
    logic [15:0] o_rdata;
    logic        o_hit;

    integer seed;

    // Reference model of the memory image and the tag, valid and LRU state
    logic [15:0] mem_img [logic [15:0]];
    logic        m_valid [2][2];
    logic [12:0] m_tag   [2][2];
    logic        m_lru   [2];

    cache_top #(
        .MEM_LATENCY (MEM_LATENCY)
    ) i_dut (
        .clk     (clk),
        .reset_n (reset_n),
        .i_rd    (i_rd),
        .i_wr    (i_wr),
        .i_addr  (i_addr),
        .i_wdata (i_wdata),
        .o_ready (o_ready),
        .o_done  (o_done),
        .o_rdata (o_rdata),
        .o_hit   (o_hit)
    );

    bind cache_ctrl cache_properties u_props (
        .clk       (clk),
        .reset_n   (reset_n),
        .i_rd      (i_rd),
        .i_wr      (i_wr),
        .i_hit     (i_hit),
        .i_mem_ack (i_mem_ack),
        .o_ready   (o_ready),
        .o_done    (o_done)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic stop_with_failure();
        $display("TEST FAIL");
        $fatal(1, "Stopping at first error");
    endtask

    task automatic check_value(input string name, input logic [15:0] actual,
                               input logic [15:0] expected);
        if (actual !== expected) begin
            $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
            stop_with_failure();
        end
    endtask

    // Unwritten words still hold their preload value
    function automatic logic [15:0] image_read(input logic [15:0] addr);
        if (mem_img.exists(addr)) begin
            return mem_img[addr];
        end
        return addr ^ 16'hA5C3;
    endfunction

    function automatic void model_access(input logic is_wr, input logic [15:0] addr,
                                         input logic [15:0] wdata, output logic hit,
                                         output logic [15:0] rdata);
        logic        set;
        logic [12:0] tag;
        logic        way;
        logic        victim;
        set = addr[2];
        tag = addr[15:3];
        hit = 1'b0;
        way = 1'b0;
        for (int w = 0; w < 2; w++) begin
            if (m_valid[set][w] && m_tag[set][w] == tag) begin
                hit = 1'b1;
                way = w[0];
            end
        end
        if (hit) begin
            m_lru[set] = ~way;
        end
        if (is_wr) begin
            // Write-through with no allocation on a miss
            mem_img[addr] = wdata;
            rdata = wdata;
        end else begin
            rdata = image_read(addr);
            if (!hit) begin
                victim = !m_valid[set][0] ? 1'b0 : (!m_valid[set][1] ? 1'b1 : m_lru[set]);
                m_valid[set][victim] = 1'b1;
                m_tag[set][victim] = tag;
                m_lru[set] = ~victim;
            end
        end
    endfunction

    task automatic wait_ready();
        int cycles;
        cycles = 0;
        while (o_ready !== 1'b1) begin
            if (cycles >= TIMEOUT) begin
                $display("Timed out at %0t ns waiting for the cache to become ready", $time);
                stop_with_failure();
            end
            @(posedge clk);
            #2;
            cycles++;
        end
    endtask

    task automatic wait_done();
        int cycles;
        cycles = 0;
        while (o_done !== 1'b1) begin
            if (cycles >= TIMEOUT) begin
                $display("Timed out at %0t ns waiting for the access to finish", $time);
                stop_with_failure();
            end
            @(posedge clk);
            #2;
            cycles++;
        end
    endtask

    // Runs one access starting 2 ns after a rising edge
    task automatic run_access(input logic is_wr, input logic [15:0] addr,
                              input logic [15:0] wdata);
        logic        exp_hit;
        logic [15:0] exp_data;
        model_access(is_wr, addr, wdata, exp_hit, exp_data);
        wait_ready();
        i_rd    = ~is_wr;
        i_wr    = is_wr;
        i_addr  = addr;
        i_wdata = wdata;
        @(posedge clk);
        #2;
        i_rd = 1'b0;
        i_wr = 1'b0;
        // Busy from the cycle after the strobe
        check_value("o_ready", {15'b0, o_ready}, 16'd0);
        wait_done();
        check_value("o_ready", {15'b0, o_ready}, 16'd1);
        check_value("o_hit", {15'b0, o_hit}, {15'b0, exp_hit});
        if (!is_wr) begin
            check_value("o_rdata", o_rdata, exp_data);
        end
    endtask

    initial begin
        logic [31:0] rnd;
        logic [15:0] addr;
        seed    = 25507;
        reset_n = 1'b0;
        i_rd    = 1'b0;
        i_wr    = 1'b0;
        i_addr  = '0;
        i_wdata = '0;
        for (int s = 0; s < 2; s++) begin
            m_lru[s] = 1'b0;
            m_valid[s][0] = 1'b0;
            m_valid[s][1] = 1'b0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        reset_n = 1'b1;

        check_value("o_ready", {15'b0, o_ready}, 16'd1);
        check_value("o_done", {15'b0, o_done}, 16'd0);
        check_value("o_hit", {15'b0, o_hit}, 16'd0);

        // Cold miss, then a hit on the same word
        run_access(1'b0, 16'h1234, 16'h0000);
        run_access(1'b0, 16'h1234, 16'h0000);
        // Write hit merges into the cached line
        run_access(1'b1, 16'h1235, 16'hBEEF);
        run_access(1'b0, 16'h1235, 16'h0000);
        // Write miss leaves the line uncached
        run_access(1'b1, 16'h2A40, 16'h5A5A);
        run_access(1'b0, 16'h2A40, 16'h0000);

        // Three tags fighting over set 0
        run_access(1'b0, 16'h4000, 16'h0000);
        run_access(1'b0, 16'h4008, 16'h0000);
        run_access(1'b0, 16'h4001, 16'h0000);
        run_access(1'b0, 16'h4010, 16'h0000);
        run_access(1'b0, 16'h4002, 16'h0000);
        run_access(1'b0, 16'h400B, 16'h0000);
        run_access(1'b0, 16'h4013, 16'h0000);

        for (int n = 0; n < NUM_OPS; n++) begin
            rnd  = $random(seed);
            addr = {TAG_BASE, rnd[3:2], rnd[4], rnd[6:5]};
            run_access(rnd[1:0] == 2'b00, addr, rnd[31:16]);
        end

        repeat (4) @(posedge clk);
        if (i_dut.u_ctrl.u_props.fail_count == 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            $display("Assertion failures seen: %0d", i_dut.u_ctrl.u_props.fail_count);
            stop_with_failure();
        end
    end

endmodule

/* cache_top.sv */
module cache_top
    import cache_pkg::*;
#(
    parameter int MEM_LATENCY = 4
) (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              i_rd,
    input  logic              i_wr,
    input  logic [WORD_W-1:0] i_addr,
    input  logic [WORD_W-1:0] i_wdata,
    output logic              o_ready,
    output logic              o_done,
    output logic [WORD_W-1:0] o_rdata,
    output logic              o_hit
);

    logic [WORD_W-1:0] arr_addr;
    logic              arr_way;
    logic              touch;
    logic              tag_fill;
    logic              data_wr;
    logic              data_fill;
    logic [LINE_W-1:0] fill_line;
    logic [WORD_W-1:0] arr_wdata;
    logic              hit;
    logic              hit_way;
    logic              victim_way;
    logic [WORD_W-1:0] rword;
    logic              mem_rd;
    logic              mem_wr;
    logic [WORD_W-1:0] mem_addr;
    logic [WORD_W-1:0] mem_wdata;
    logic              mem_ack;
    logic [LINE_W-1:0] mem_rline;

    cache_ctrl u_ctrl (
        .clk          (clk),
        .reset_n      (reset_n),
        .i_rd         (i_rd),
        .i_wr         (i_wr),
        .i_addr       (i_addr),
        .i_wdata      (i_wdata),
        .i_hit        (hit),
        .i_hit_way    (hit_way),
        .i_victim_way (victim_way),
        .i_rword      (rword),
        .i_mem_ack    (mem_ack),
        .i_mem_rline  (mem_rline),
        .o_ready      (o_ready),
        .o_done       (o_done),
        .o_rdata      (o_rdata),
        .o_hit        (o_hit),
        .o_arr_addr   (arr_addr),
        .o_arr_way    (arr_way),
        .o_touch      (touch),
        .o_tag_fill   (tag_fill),
        .o_data_wr    (data_wr),
        .o_data_fill  (data_fill),
        .o_fill_line  (fill_line),
        .o_wdata      (arr_wdata),
        .o_mem_rd     (mem_rd),
        .o_mem_wr     (mem_wr),
        .o_mem_addr   (mem_addr),
        .o_mem_wdata  (mem_wdata)
    );

    // Touch and fill both act on the latched request address
    cache_tag_array u_tags (
        .clk           (clk),
        .reset_n       (reset_n),
        .i_lookup_addr (arr_addr),
        .i_touch       (touch),
        .i_touch_way   (arr_way),
        .i_fill        (tag_fill),
        .i_fill_way    (arr_way),
        .i_fill_addr   (arr_addr),
        .o_hit         (hit),
        .o_hit_way     (hit_way),
        .o_victim_way  (victim_way)
    );

    cache_data_array u_data (
        .clk         (clk),
        .i_addr      (arr_addr[OFF_W:0]),
        .i_way       (arr_way),
        .i_wr        (data_wr),
        .i_wr_off    (arr_addr[OFF_W-1:0]),
        .i_wdata     (arr_wdata),
        .i_fill      (data_fill),
        .i_fill_line (fill_line),
        .o_rword     (rword)
    );

    main_memory #(
        .MEM_LATENCY (MEM_LATENCY)
    ) u_mem (
        .clk     (clk),
        .reset_n (reset_n),
        .i_rd    (mem_rd),
        .i_wr    (mem_wr),
        .i_addr  (mem_addr),
        .i_wdata (mem_wdata),
        .o_ack   (mem_ack),
        .o_rline (mem_rline)
    );

endmodule

/* main_memory.sv */
module main_memory
    import cache_pkg::*;
#(
    parameter int MEM_LATENCY = 4
) (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              i_rd,
    input  logic              i_wr,
    input  logic [WORD_W-1:0] i_addr,
    input  logic [WORD_W-1:0] i_wdata,
    output logic              o_ack,
    output logic [LINE_W-1:0] o_rline
);

    localparam int CNT_W = $clog2(MEM_LATENCY + 1);

    logic [WORD_W-1:0] mem [2**WORD_W];
    logic              pending;
    logic [CNT_W-1:0]  cnt;
    logic [WORD_W-1:0] addr_q;
    logic [WORD_W-1:0] wdata_q;
    logic              wr_q;

    // Every word starts out as its address XOR a fixed pattern
    initial begin
        for (int i = 0; i < 2**WORD_W; i++) begin
            mem[i] = WORD_W'(i) ^ 16'hA5C3;
        end
    end

    // Ack lands MEM_LATENCY cycles after the strobe
    assign o_ack = pending && (cnt == '0);

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            pending <= 1'b0;
            cnt     <= '0;
        end else if (i_rd || i_wr) begin
            pending <= 1'b1;
            cnt     <= CNT_W'(MEM_LATENCY - 1);
        end else if (o_ack) begin
            pending <= 1'b0;
        end else if (pending) begin
            cnt <= cnt - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (i_rd || i_wr) begin
            addr_q  <= i_addr;
            wdata_q <= i_wdata;
            wr_q    <= i_wr;
        end
    end

    always @(posedge clk) begin
        if (o_ack && wr_q) begin
            mem[addr_q] <= wdata_q;
        end
    end

    // Aligned line, lowest address in the low word
    always_comb begin
        for (int w = 0; w < LINE_WORDS; w++) begin
            o_rline[w*WORD_W +: WORD_W] = mem[{addr_q[WORD_W-1:OFF_W], OFF_W'(w)}];
        end
    end

endmodule
